/* logic/pixelGen_cfg.svh */
// pixel generator config: bus geometry, block base, default raster timing, counter widths
`ifndef PIXELGEN_CFG_SVH
`define PIXELGEN_CFG_SVH

// bus geometry
`define PG_ADDR_WIDTH   16
`define PG_BLOCK_BASE   8'h05   // adr[15:8] for this block

// counter and field widths
`define PG_H_WIDTH      11
`define PG_V_WIDTH      11
`define PG_PORCH_WIDTH  7       // front, back and pulse fields

// default panel timing, 480x272 glass
`define PG_H_DISPLAY    480
`define PG_H_FRONT      8
`define PG_H_BACK       43
`define PG_H_PULSE      30
`define PG_V_DISPLAY    272
`define PG_V_FRONT      12
`define PG_V_BACK       4
`define PG_V_PULSE      10

`endif

/* logic/pixelBusPkg.sv */
// register bus package: register map offsets and Wishbone slave states
`default_nettype none

package pixelBusPkg;

	//--------------------------------------------------
	// register map, byte offsets inside the block
	//--------------------------------------------------
	typedef enum logic [7:0]
	{
		regSize      = 8'h00,   // {vDisplay, hDisplay}
		regBack      = 8'h04,   // {vBack, hBack}
		regFront     = 8'h08,   // {vFront, hFront}
		regPulse     = 8'h0C,   // {vPulse, hPulse}
		regDispRst   = 8'h10,   // bit 0
		regBlDuty    = 8'h14,   // bits 7..0
		regSyncStart = 8'h80,   // read only from here on
		regSyncEnd   = 8'h84,
		regSyncMax   = 8'h88
	} pgRegE;

	// slave ack state
	typedef enum logic
	{
		wbIdle = 1'b0,
		wbAck  = 1'b1
	} wbStateE;

endpackage

`default_nettype wire

/* logic/pixelTimingPkg.sv */
// raster timing package: counter types and horizontal phase encoding
`default_nettype none

`include "pixelGen_cfg.svh"

package pixelTimingPkg;

	// one bit wider than the display width so porches fit
	typedef logic [`PG_H_WIDTH:0] hCountT;
	typedef logic [`PG_V_WIDTH:0] vCountT;

	//--------------------------------------------------
	// horizontal phase of the line
	//--------------------------------------------------
	typedef enum logic [1:0]
	{
		phActive = 2'd0,
		phFront  = 2'd1,
		phSync   = 2'd2,
		phBack   = 2'd3
	} phaseE;

endpackage

`default_nettype wire

/* logic/pixelCsrIf.sv */
// timing register interface: programmed and derived values from CSR to raster and PWM
`timescale 1ns/1ps
`default_nettype none

`include "pixelGen_cfg.svh"

interface pixelCsrIf;

	logic [`PG_H_WIDTH-1:0]     hDisplay;
	logic [`PG_V_WIDTH-1:0]     vDisplay;
	pixelTimingPkg::hCountT     hSyncStart;
	pixelTimingPkg::hCountT     hSyncEnd;
	pixelTimingPkg::hCountT     hSyncMax;   // line total minus 1
	pixelTimingPkg::vCountT     vSyncStart;
	pixelTimingPkg::vCountT     vSyncEnd;
	pixelTimingPkg::vCountT     vSyncMax;   // frame total minus 1
	logic                       displayRst;
	logic [7:0]                 blDuty;

	modport csr (output hDisplay, vDisplay, hSyncStart, hSyncEnd, hSyncMax,
		vSyncStart, vSyncEnd, vSyncMax, displayRst, blDuty);

	modport timing (input hDisplay, vDisplay, hSyncStart, hSyncEnd, hSyncMax,
		vSyncStart, vSyncEnd, vSyncMax, displayRst);

	modport pwm (input blDuty);

endinterface

`default_nettype wire

/* logic/PixelGenCsr.sv */
// display timing CSR block: Wishbone classic slave, register map, derived sync bounds
`timescale 1ns/1ps
`default_nettype none

`include "pixelGen_cfg.svh"

module PixelGenCsr
(
	input  wire                         iSysClk,
	input  wire                         rstN,
	input  wire                         wbCyc,
	input  wire                         wbStb,
	input  wire                         wbWe,
	input  wire [`PG_ADDR_WIDTH-1:0]    wbAdr,
	input  wire [31:0]                  wbDatW,
	output logic [31:0]                 wbDatR,
	output logic                        wbAck,
	pixelCsrIf.csr                      regs
);

	// derived bounds out of reset, from the default timing
	localparam pixelTimingPkg::hCountT hStartRst =
		pixelTimingPkg::hCountT'(`PG_H_DISPLAY + `PG_H_FRONT);
	localparam pixelTimingPkg::hCountT hEndRst =
		pixelTimingPkg::hCountT'(`PG_H_DISPLAY + `PG_H_FRONT + `PG_H_PULSE - 1);
	localparam pixelTimingPkg::hCountT hMaxRst = pixelTimingPkg::hCountT'(
		`PG_H_DISPLAY + `PG_H_FRONT + `PG_H_PULSE + `PG_H_BACK - 1);
	localparam pixelTimingPkg::vCountT vStartRst =
		pixelTimingPkg::vCountT'(`PG_V_DISPLAY + `PG_V_FRONT);
	localparam pixelTimingPkg::vCountT vEndRst =
		pixelTimingPkg::vCountT'(`PG_V_DISPLAY + `PG_V_FRONT + `PG_V_PULSE - 1);
	localparam pixelTimingPkg::vCountT vMaxRst = pixelTimingPkg::vCountT'(
		`PG_V_DISPLAY + `PG_V_FRONT + `PG_V_PULSE + `PG_V_BACK - 1);

	pixelBusPkg::wbStateE       ackState;
	pixelBusPkg::pgRegE         offset;
	logic                       blockSel;
	logic                       reqTake;    // new access accepted this cycle
	logic                       wrTake;
	logic [31:0]                rdMux;

	logic [`PG_PORCH_WIDTH-1:0] hFront, hBack, hPulse;
	logic [`PG_PORCH_WIDTH-1:0] vFront, vBack, vPulse;
	pixelTimingPkg::hCountT     hFrontEnd, hPulseEnd, hLineEnd;
	pixelTimingPkg::vCountT     vFrontEnd, vPulseEnd, vFrameEnd;

	//--------------------------------------------------
	// decode and ack
	//--------------------------------------------------
	assign offset   = pixelBusPkg::pgRegE'(wbAdr[7:0]);
	assign blockSel = (wbAdr[`PG_ADDR_WIDTH-1:8] == `PG_BLOCK_BASE);
	assign reqTake  = wbCyc && wbStb && blockSel && (ackState == pixelBusPkg::wbIdle);
	assign wrTake   = reqTake && wbWe;
	assign wbAck    = (ackState == pixelBusPkg::wbAck);

	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
			ackState <= pixelBusPkg::wbIdle;
		else if (reqTake)
			ackState <= pixelBusPkg::wbAck;
		else
			ackState <= pixelBusPkg::wbIdle;   // ack lasts one cycle
	end

	// running sums for the bounds
	assign hFrontEnd = pixelTimingPkg::hCountT'(regs.hDisplay) + pixelTimingPkg::hCountT'(hFront);
	assign hPulseEnd = hFrontEnd + pixelTimingPkg::hCountT'(hPulse);
	assign hLineEnd  = hPulseEnd + pixelTimingPkg::hCountT'(hBack);
	assign vFrontEnd = pixelTimingPkg::vCountT'(regs.vDisplay) + pixelTimingPkg::vCountT'(vFront);
	assign vPulseEnd = vFrontEnd + pixelTimingPkg::vCountT'(vPulse);
	assign vFrameEnd = vPulseEnd + pixelTimingPkg::vCountT'(vBack);

	//--------------------------------------------------
	// register map and derived bounds
	//--------------------------------------------------
	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			regs.hDisplay   <= `PG_H_WIDTH'(`PG_H_DISPLAY);
			regs.vDisplay   <= `PG_V_WIDTH'(`PG_V_DISPLAY);
			hFront          <= `PG_PORCH_WIDTH'(`PG_H_FRONT);
			hBack           <= `PG_PORCH_WIDTH'(`PG_H_BACK);
			hPulse          <= `PG_PORCH_WIDTH'(`PG_H_PULSE);
			vFront          <= `PG_PORCH_WIDTH'(`PG_V_FRONT);
			vBack           <= `PG_PORCH_WIDTH'(`PG_V_BACK);
			vPulse          <= `PG_PORCH_WIDTH'(`PG_V_PULSE);
			regs.displayRst <= 1'b0;
			regs.blDuty     <= 8'd0;
			regs.hSyncStart <= hStartRst;
			regs.hSyncEnd   <= hEndRst;
			regs.hSyncMax   <= hMaxRst;
			regs.vSyncStart <= vStartRst;
			regs.vSyncEnd   <= vEndRst;
			regs.vSyncMax   <= vMaxRst;
		end
		else
		begin
			if (wrTake)
			begin
				case (offset)
					pixelBusPkg::regSize:
					begin
						regs.hDisplay <= wbDatW[`PG_H_WIDTH-1:0];
						regs.vDisplay <= wbDatW[16 +: `PG_V_WIDTH];
					end
					pixelBusPkg::regBack:
					begin
						hBack <= wbDatW[`PG_PORCH_WIDTH-1:0];
						vBack <= wbDatW[16 +: `PG_PORCH_WIDTH];
					end
					pixelBusPkg::regFront:
					begin
						hFront <= wbDatW[`PG_PORCH_WIDTH-1:0];
						vFront <= wbDatW[16 +: `PG_PORCH_WIDTH];
					end
					pixelBusPkg::regPulse:
					begin
						hPulse <= wbDatW[`PG_PORCH_WIDTH-1:0];
						vPulse <= wbDatW[16 +: `PG_PORCH_WIDTH];
					end
					pixelBusPkg::regDispRst: regs.displayRst <= wbDatW[0];
					pixelBusPkg::regBlDuty:  regs.blDuty     <= wbDatW[7:0];
					default: ;  // read-only and holes ignore writes
				endcase
			end
			// bounds follow the base registers one cycle later
			regs.hSyncStart <= hFrontEnd;
			regs.hSyncEnd   <= hPulseEnd - 1'b1;
			regs.hSyncMax   <= hLineEnd - 1'b1;
			regs.vSyncStart <= vFrontEnd;
			regs.vSyncEnd   <= vPulseEnd - 1'b1;
			regs.vSyncMax   <= vFrameEnd - 1'b1;
		end
	end

	//--------------------------------------------------
	// readback
	//--------------------------------------------------
	always_comb
	begin
		case (offset)
			pixelBusPkg::regSize:
				rdMux = {{(16-`PG_V_WIDTH){1'b0}}, regs.vDisplay,
					{(16-`PG_H_WIDTH){1'b0}}, regs.hDisplay};
			pixelBusPkg::regBack:
				rdMux = {{(16-`PG_PORCH_WIDTH){1'b0}}, vBack, {(16-`PG_PORCH_WIDTH){1'b0}}, hBack};
			pixelBusPkg::regFront:
				rdMux = {{(16-`PG_PORCH_WIDTH){1'b0}}, vFront, {(16-`PG_PORCH_WIDTH){1'b0}}, hFront};
			pixelBusPkg::regPulse:
				rdMux = {{(16-`PG_PORCH_WIDTH){1'b0}}, vPulse, {(16-`PG_PORCH_WIDTH){1'b0}}, hPulse};
			pixelBusPkg::regDispRst: rdMux = {31'd0, regs.displayRst};
			pixelBusPkg::regBlDuty:  rdMux = {24'd0, regs.blDuty};
			pixelBusPkg::regSyncStart:
				rdMux = {{(15-`PG_V_WIDTH){1'b0}}, regs.vSyncStart,
					{(15-`PG_H_WIDTH){1'b0}}, regs.hSyncStart};
			pixelBusPkg::regSyncEnd:
				rdMux = {{(15-`PG_V_WIDTH){1'b0}}, regs.vSyncEnd,
					{(15-`PG_H_WIDTH){1'b0}}, regs.hSyncEnd};
			pixelBusPkg::regSyncMax:
				rdMux = {{(15-`PG_V_WIDTH){1'b0}}, regs.vSyncMax,
					{(15-`PG_H_WIDTH){1'b0}}, regs.hSyncMax};
			default: rdMux = 32'd0;    // unmapped in-block offset
		endcase
	end

	// captured with the ack edge, held while ack is high
	always_ff @(posedge iSysClk)
	begin
		if (reqTake)
			wbDatR <= rdMux;
	end

endmodule

`default_nettype wire

/* logic/PixelTimingGen.sv */
// raster timing generator: line and frame counters, sync and data-enable
`timescale 1ns/1ps
`default_nettype none

`include "pixelGen_cfg.svh"

module PixelTimingGen
(
	input  wire                 iSysClk,
	input  wire                 rstN,
	pixelCsrIf.timing           regs,
	output logic                hSync,
	output logic                vSync,
	output logic                de,
	output pixelTimingPkg::hCountT xPos,
	output pixelTimingPkg::vCountT yPos
);

	// reset parks the raster on the last pixel of the default frame,
	// so the outputs idle low and the first edge wraps to 0,0
	localparam pixelTimingPkg::hCountT hPark = pixelTimingPkg::hCountT'(
		`PG_H_DISPLAY + `PG_H_FRONT + `PG_H_PULSE + `PG_H_BACK - 1);
	localparam pixelTimingPkg::vCountT vPark = pixelTimingPkg::vCountT'(
		`PG_V_DISPLAY + `PG_V_FRONT + `PG_V_PULSE + `PG_V_BACK - 1);

	pixelTimingPkg::phaseE      phase;
	logic                       lineEnd;
	logic                       frameEnd;
	logic                       vActive;
	logic                       vInSync;

	// >= so a shrunk timing never lets the counter run away
	assign lineEnd  = (xPos >= regs.hSyncMax);
	assign frameEnd = (yPos >= regs.vSyncMax);

	//--------------------------------------------------
	// counters
	//--------------------------------------------------
	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			xPos <= hPark;
			yPos <= vPark;
		end
		else if (regs.displayRst)
		begin
			xPos <= '0;     // frozen at origin
			yPos <= '0;
		end
		else if (lineEnd)
		begin
			xPos <= '0;
			yPos <= frameEnd ? '0 : yPos + 1'b1;
		end
		else
			xPos <= xPos + 1'b1;
	end

	// horizontal phase from the current column
	always_comb
	begin
		if (xPos < {1'b0, regs.hDisplay})
			phase = pixelTimingPkg::phActive;
		else if (xPos < regs.hSyncStart)
			phase = pixelTimingPkg::phFront;
		else if (xPos <= regs.hSyncEnd)
			phase = pixelTimingPkg::phSync;
		else
			phase = pixelTimingPkg::phBack;
	end

	assign vActive = (yPos < {1'b0, regs.vDisplay});
	assign vInSync = (yPos >= regs.vSyncStart) && (yPos <= regs.vSyncEnd);

	// zero latency outputs
	assign hSync = !regs.displayRst && (phase == pixelTimingPkg::phSync);
	assign vSync = !regs.displayRst && vInSync;
	assign de    = !regs.displayRst && vActive && (phase == pixelTimingPkg::phActive);

endmodule

`default_nettype wire

/* logic/BacklightPwm.sv */
// backlight PWM: 255-cycle period, high while the count is below the duty
`timescale 1ns/1ps
`default_nettype none

module BacklightPwm
(
	input  wire         iSysClk,
	input  wire         rstN,
	pixelCsrIf.pwm      regs,
	output logic        backlight
);

	logic [7:0] pwmCnt;     // 0..254

	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			pwmCnt    <= 8'd0;
			backlight <= 1'b0;
		end
		else
		begin
			pwmCnt    <= (pwmCnt == 8'd254) ? 8'd0 : pwmCnt + 1'b1;
			backlight <= (pwmCnt < regs.blDuty);   // 255 stays on, 0 stays off
		end
	end

endmodule

`default_nettype wire

/* logic/PixelGenTop.sv */
// LCD display timing top: Wishbone CSR, raster generator and backlight PWM
`timescale 1ns/1ps
`default_nettype none

`include "pixelGen_cfg.svh"

module PixelGenTop
(
	input  wire                         iSysClk,
	input  wire                         rstN,
	// Wishbone slave
	input  wire                         wbCyc,
	input  wire                         wbStb,
	input  wire                         wbWe,
	input  wire [`PG_ADDR_WIDTH-1:0]    wbAdr,
	input  wire [31:0]                  wbDatW,
	output logic [31:0]                 wbDatR,
	output logic                        wbAck,
	// panel side
	output logic                        hSync,
	output logic                        vSync,
	output logic                        de,
	output pixelTimingPkg::hCountT      xPos,
	output pixelTimingPkg::vCountT      yPos,
	output logic                        lcdRst,
	output logic                        backlight
);

	pixelCsrIf csrBus();

	PixelGenCsr uCsr (.iSysClk(iSysClk), .rstN(rstN), .wbCyc(wbCyc), .wbStb(wbStb),
		.wbWe(wbWe), .wbAdr(wbAdr), .wbDatW(wbDatW), .wbDatR(wbDatR), .wbAck(wbAck),
		.regs(csrBus.csr));

	PixelTimingGen uTiming (.iSysClk(iSysClk), .rstN(rstN), .regs(csrBus.timing),
		.hSync(hSync), .vSync(vSync), .de(de), .xPos(xPos), .yPos(yPos));

	BacklightPwm uPwm (.iSysClk(iSysClk), .rstN(rstN), .regs(csrBus.pwm),
		.backlight(backlight));

	assign lcdRst = csrBus.displayRst;  // panel reset straight from the register

endmodule

`default_nettype wire

/* verif/tbClkGen.sv */
// testbench clock source: 40 ns system clock and a 16-cycle active-low reset
`timescale 1ns/1ps
`default_nettype none

module tbClkGen
(
	output logic iSysClk,
	output logic rstN
);

	initial
	begin
		iSysClk = 1'b0;
		forever #20 iSysClk = ~iSysClk;   // 25 MHz
	end

	initial
	begin
		rstN = 1'b0;
		repeat (16) @(posedge iSysClk);
		@(negedge iSysClk);     // release away from the active edge
		rstN = 1'b1;
	end

endmodule

`default_nettype wire

/* verif/PixelGenTb.sv */
// display timing testbench: Wishbone register checks, raster, display reset and backlight
`timescale 1ns/1ps
`default_nettype none

`include "pixelGen_cfg.svh"

module PixelGenTb;

	localparam int smallFrame = 17 * 8;     // 17 pixel lines, 8 lines
	localparam int pwmCycles  = 6 * 260;    // six duty windows
	localparam int cycleLimit = 16 + 4 * smallFrame + pwmCycles + 300;

	logic iSysClk, rstN;
	logic wbCyc, wbStb, wbWe, wbAck;
	logic [`PG_ADDR_WIDTH-1:0] wbAdr;
	logic [31:0] wbDatW, wbDatR;
	logic hSync, vSync, de, lcdRst, backlight;
	pixelTimingPkg::hCountT xPos;
	pixelTimingPkg::vCountT yPos;

	// reference register model
	int hDisp = `PG_H_DISPLAY, hFr = `PG_H_FRONT, hBk = `PG_H_BACK, hPu = `PG_H_PULSE;
	int vDisp = `PG_V_DISPLAY, vFr = `PG_V_FRONT, vBk = `PG_V_BACK, vPu = `PG_V_PULSE;
	int dispRst = 0, duty = 0;
	int cycleCnt = 0;
	logic [31:0] rnd, rd;
	logic acked;

	tbClkGen uClk (.iSysClk(iSysClk), .rstN(rstN));

	PixelGenTop DUT (.iSysClk(iSysClk), .rstN(rstN), .wbCyc(wbCyc), .wbStb(wbStb),
		.wbWe(wbWe), .wbAdr(wbAdr), .wbDatW(wbDatW), .wbDatR(wbDatR), .wbAck(wbAck),
		.hSync(hSync), .vSync(vSync), .de(de), .xPos(xPos), .yPos(yPos),
		.lcdRst(lcdRst), .backlight(backlight));

	task automatic stopOnError(input string msg);
		$display("ERROR at %0t ns: %s", $time, msg);
		$display("Test failures found");
		$fatal(1, "stopped at first error");
	endtask

	function automatic logic [31:0] pair16(input int v, input int h);
		return {v[15:0], h[15:0]};
	endfunction

	// derived bounds are 12 bits, so negative sums wrap
	function automatic logic [31:0] boundPair(input int v, input int h);
		return {4'd0, v[11:0], 4'd0, h[11:0]};
	endfunction

	//--------------------------------------------------
	// Wishbone master
	//--------------------------------------------------
	task automatic busCycle(input logic we, input logic [15:0] adr, input logic [31:0] dat,
		output logic [31:0] rdData, output logic gotAck);
		int waitCnt;
		@(negedge iSysClk);
		wbCyc  = 1'b1;
		wbStb  = 1'b1;
		wbWe   = we;
		wbAdr  = adr;
		wbDatW = dat;
		waitCnt = 0;
		gotAck  = 1'b0;
		rdData  = '0;
		while (!gotAck && waitCnt < 4)  // 4 cycles is plenty for a one-wait slave
		begin
			@(negedge iSysClk);
			waitCnt++;
			gotAck = wbAck;
		end
		if (gotAck)
		begin
			rdData = wbDatR;
			assert (waitCnt == 1)
				else stopOnError($sformatf("ack after %0d cycles, expected 1", waitCnt));
		end
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe  = 1'b0;
	endtask

	task automatic writeReg(input logic [7:0] off, input logic [31:0] dat);
		logic [31:0] unused;
		logic gotAck;
		busCycle(1'b1, {`PG_BLOCK_BASE, off}, dat, unused, gotAck);
		assert (gotAck) else stopOnError($sformatf("write to offset %h not acknowledged", off));
	endtask

	task automatic readCheck(input logic [7:0] off, input logic [31:0] expVal, input string what);
		logic [31:0] got;
		logic gotAck;
		busCycle(1'b0, {`PG_BLOCK_BASE, off}, 32'd0, got, gotAck);
		assert (gotAck) else stopOnError($sformatf("read of %s not acknowledged", what));
		assert (got === expVal)
			else stopOnError($sformatf("%s read %h, expected %h", what, got, expVal));
	endtask

	// derived bounds first, so the first one lands two cycles after the last write
	task automatic checkAllRegs();
		readCheck(8'h80, boundPair(vDisp + vFr, hDisp + hFr), "sync start");
		readCheck(8'h84, boundPair(vDisp + vFr + vPu - 1, hDisp + hFr + hPu - 1), "sync end");
		readCheck(8'h88, boundPair(vDisp + vFr + vPu + vBk - 1, hDisp + hFr + hPu + hBk - 1),
			"sync max");
		readCheck(8'h00, pair16(vDisp, hDisp), "size");
		readCheck(8'h04, pair16(vBk, hBk), "back porch");
		readCheck(8'h08, pair16(vFr, hFr), "front porch");
		readCheck(8'h0C, pair16(vPu, hPu), "sync pulse");
		readCheck(8'h10, dispRst, "display reset");
		readCheck(8'h14, duty, "backlight duty");
	endtask

	//--------------------------------------------------
	// raster and backlight checkers
	//--------------------------------------------------
	task automatic checkRaster(input int frames);
		int ex, ey, deCnt, hsCnt, vsLines, lineLen, frameLen;
		lineLen  = hDisp + hFr + hPu + hBk;
		frameLen = vDisp + vFr + vPu + vBk;
		ex = 0;
		ey = 0;
		deCnt = 0;
		hsCnt = 0;
		vsLines = 0;
		repeat (frames * frameLen * lineLen)
		begin
			assert (xPos == ex && yPos == ey)
				else stopOnError($sformatf("raster at (%0d,%0d), expected (%0d,%0d)",
					xPos, yPos, ex, ey));
			assert (de == (ex < hDisp && ey < vDisp)) else stopOnError("de mismatch");
			assert (hSync == (ex >= hDisp + hFr && ex < hDisp + hFr + hPu))
				else stopOnError("hSync mismatch");
			assert (vSync == (ey >= vDisp + vFr && ey < vDisp + vFr + vPu))
				else stopOnError("vSync mismatch");
			deCnt += de;
			hsCnt += hSync;
			if (ex == lineLen - 1)
			begin
				assert (deCnt == ((ey < vDisp) ? hDisp : 0)) else stopOnError("de width per line");
				assert (hsCnt == hPu) else stopOnError("hSync width per line");
				vsLines += vSync;
				deCnt = 0;
				hsCnt = 0;
				ex = 0;
				if (ey == frameLen - 1)
				begin
					assert (vsLines == vPu) else stopOnError("vSync lines per frame");
					vsLines = 0;
					ey = 0;
				end
				else
					ey++;
			end
			else
				ex++;
			@(negedge iSysClk);
		end
	endtask

	task automatic checkBacklight(input int dutyVal);
		int highCnt;
		writeReg(8'h14, dutyVal);
		duty = dutyVal;
		repeat (2) @(negedge iSysClk);  // registered compare settles
		highCnt = 0;
		repeat (255)
		begin
			highCnt += backlight;
			@(negedge iSysClk);
		end
		assert (highCnt == dutyVal)
			else stopOnError($sformatf("duty %0d gave %0d high cycles", dutyVal, highCnt));
	endtask

	// bus and freeze rules checked on every edge
	ackOnePulse: assert property (@(posedge iSysClk) disable iff (!rstN) wbAck |=> !wbAck)
		else stopOnError("wbAck held longer than one cycle");
	freezeOut: assert property (@(posedge iSysClk) disable iff (!rstN)
		lcdRst |-> !de && !hSync && !vSync)
		else stopOnError("outputs active under display reset");
	freezeCnt: assert property (@(posedge iSysClk) disable iff (!rstN)
		lcdRst |=> xPos == '0 && yPos == '0)
		else stopOnError("counters moving under display reset");

	always @(posedge iSysClk)
	begin
		cycleCnt <= cycleCnt + 1;
		if (cycleCnt >= cycleLimit)
		begin
			$display("Timeout: run still busy after %0d clock cycles", cycleLimit);
			$display("Test failures found");
			$fatal(1, "timeout");
		end
	end

	initial
	begin
		wbCyc  = 1'b0;
		wbStb  = 1'b0;
		wbWe   = 1'b0;
		wbAdr  = '0;
		wbDatW = '0;
		void'($urandom(32'h43cf9d1e));
		@(posedge rstN);
		assert (!wbAck && !de && !hSync && !vSync && !backlight && !lcdRst)
			else stopOnError("outputs not low out of reset");
		checkAllRegs();

		// random words, upper bits must come back as zero
		repeat (3)
		begin
			rnd = $urandom();
			writeReg(8'h00, rnd);
			hDisp = rnd[10:0];
			vDisp = rnd[26:16];
			rnd = $urandom();
			writeReg(8'h04, rnd);
			hBk = rnd[6:0];
			vBk = rnd[22:16];
			rnd = $urandom();
			writeReg(8'h08, rnd);
			hFr = rnd[6:0];
			vFr = rnd[22:16];
			rnd = $urandom();
			writeReg(8'h0C, rnd);
			hPu = rnd[6:0];
			vPu = rnd[22:16];
			checkAllRegs();
		end
		writeReg(8'h80, $urandom());    // read-only
		writeReg(8'h84, $urandom());
		writeReg(8'h88, $urandom());
		checkAllRegs();

		// block select and holes
		busCycle(1'b1, 16'h0600, $urandom(), rd, acked);
		assert (!acked) else stopOnError("write outside the block was acknowledged");
		busCycle(1'b0, 16'h0A04, 32'd0, rd, acked);
		assert (!acked) else stopOnError("read outside the block was acknowledged");
		readCheck(8'h40, 32'd0, "unmapped offset");
		writeReg(8'h40, $urandom());
		checkAllRegs();

		// freeze, program the small screen, then release
		writeReg(8'h10, 32'h1);
		dispRst = 1;
		// zero size and front put both sync windows over the origin
		writeReg(8'h00, 32'h0);
		writeReg(8'h08, 32'h0);
		@(negedge iSysClk);
		repeat (20)
		begin
			assert (lcdRst && xPos == '0 && yPos == '0 && !de && !hSync && !vSync)
				else stopOnError("raster not frozen under display reset");
			@(negedge iSysClk);
		end
		writeReg(8'h00, {16'd4, 16'd8});
		writeReg(8'h08, {16'd1, 16'd2});
		writeReg(8'h04, {16'd1, 16'd4});
		writeReg(8'h0C, {16'd2, 16'd3});
		hDisp = 8;
		hFr = 2;
		hBk = 4;
		hPu = 3;
		vDisp = 4;
		vFr = 1;
		vBk = 1;
		vPu = 2;
		checkAllRegs();
		writeReg(8'h10, 32'h0);
		dispRst = 0;
		checkRaster(2);

		checkBacklight(0);
		checkBacklight(255);
		repeat (4) checkBacklight($urandom_range(1, 254));

		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+logic
logic/pixelBusPkg.sv
logic/pixelTimingPkg.sv
logic/pixelCsrIf.sv
logic/PixelGenCsr.sv
logic/PixelTimingGen.sv
logic/BacklightPwm.sv
logic/PixelGenTop.sv
verif/tbClkGen.sv
verif/PixelGenTb.sv

/* Bender.yml */
package:
  name: pixel_gen

sources:
  - include_dirs:
      - logic
    files:
      - logic/pixelBusPkg.sv
      - logic/pixelTimingPkg.sv
      - logic/pixelCsrIf.sv
      - logic/PixelGenCsr.sv
      - logic/PixelTimingGen.sv
      - logic/BacklightPwm.sv
      - logic/PixelGenTop.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verif/tbClkGen.sv
      - verif/PixelGenTb.sv
